// File: include/loader_settings.svh
`ifndef LOADER_SETTINGS_SVH
`define LOADER_SETTINGS_SVH

// MMIO and host side
`define MMIO_ADDR_W 16
`define HOST_ADDR_W 64
`define DMA_SIZE_W 43

// Line unpacking
`define LINE_W 512
`define WORD_W 32
`define WORDS_PER_LINE 16

// Descriptor fields carried in the MMIO write address
`define REGION_SIZE_W 14
`define REQ_BIT 15
`define NUM_REGIONS 3

`endif

// File: rtl/host_cfg_pkg.sv
package host_cfg_pkg;

    // Region order is also the load order
    typedef enum logic [1:0] {
        REGION_CP,
        REGION_RT,
        REGION_CONST
    } region_e;

    typedef enum logic [2:0] {
        CFG_CP,
        CFG_RT,
        CFG_CONST,
        CFG_ARMED
    } cfg_state_e;

    typedef enum logic [63:0] {
        STATUS_BUSY   = 64'd0,
        STATUS_LOADED = 64'd1
    } status_e;

endpackage

// File: rtl/dma_rd_pkg.sv
package dma_rd_pkg;

    // Walk over the regions
    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_CP,
        SEQ_RT,
        SEQ_CONST
    } seq_state_e;

    // One burst of lines
    typedef enum logic [1:0] {
        LR_IDLE,
        LR_WAIT,
        LR_UNPACK,
        LR_FINISH
    } line_state_e;

endpackage

// File: rtl/region_cfg_regs.sv
`timescale 1ns/1ns
`include "loader_settings.svh"

module region_cfg_regs import host_cfg_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     mmio_wr_en,
    input  logic [`MMIO_ADDR_W-1:0]  mmio_wr_addr,
    input  logic [`HOST_ADDR_W-1:0]  mmio_wr_data,
    input  logic                     all_done,
    output status_e                  mmio_rd_data,
    output logic                     start_pulse,
    output logic [`HOST_ADDR_W-1:0]  desc_addr [`NUM_REGIONS],
    output logic [`DMA_SIZE_W-1:0]   desc_size [`NUM_REGIONS],
    output logic [`NUM_REGIONS-1:0]  desc_req
);

    cfg_state_e state, next_state;
    logic cfg_wr;
    logic clr_wr;
    logic [`NUM_REGIONS-1:0] cfg_upd;
    logic [`DMA_SIZE_W-1:0] wr_size;

    assign cfg_wr  = mmio_wr_en && !mmio_wr_addr[0];
    assign clr_wr  = mmio_wr_en && mmio_wr_addr[0];
    assign wr_size = `DMA_SIZE_W'(mmio_wr_addr[`REGION_SIZE_W:1]);

    always_comb begin
        next_state  = state;
        cfg_upd     = '0;
        start_pulse = 1'b0;
        if (cfg_wr) begin
            case (state)
                CFG_CP: begin
                    cfg_upd[REGION_CP] = 1'b1;
                    next_state = CFG_RT;
                end
                CFG_RT: begin
                    cfg_upd[REGION_RT] = 1'b1;
                    next_state = CFG_CONST;
                end
                CFG_CONST: begin
                    cfg_upd[REGION_CONST] = 1'b1;
                    next_state = CFG_ARMED;
                end
                CFG_ARMED: begin
                    start_pulse = 1'b1;
                    next_state = CFG_CP;
                end
                default: next_state = CFG_CP;
            endcase
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state <= CFG_CP;
        end else begin
            state <= next_state;
        end
    end

    // The control program is always a single line
    always_ff @(posedge clk) begin
        for (int r = 0; r < `NUM_REGIONS; r++) begin
            if (cfg_upd[r]) begin
                desc_addr[r] <= mmio_wr_data;
                desc_size[r] <= (r == REGION_CP) ? `DMA_SIZE_W'(1) : wr_size;
            end
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            desc_req <= '0;
        end else begin
            for (int r = 0; r < `NUM_REGIONS; r++) begin
                if (cfg_upd[r]) begin
                    desc_req[r] <= mmio_wr_addr[`REQ_BIT];
                end
            end
        end
    end

    // Clear write wins over a load finishing in the same cycle
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            mmio_rd_data <= STATUS_BUSY;
        end else if (clr_wr) begin
            mmio_rd_data <= STATUS_BUSY;
        end else if (all_done) begin
            mmio_rd_data <= STATUS_LOADED;
        end
    end

    a_start_armed: assert property (@(posedge clk) disable iff (!rst_n)
        start_pulse |-> state == CFG_ARMED ##1 state == CFG_CP);

endmodule

// File: rtl/region_sequencer.sv
`timescale 1ns/1ns
`include "loader_settings.svh"

module region_sequencer import host_cfg_pkg::*, dma_rd_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start_pulse,
    input  logic [`HOST_ADDR_W-1:0]  desc_addr [`NUM_REGIONS],
    input  logic [`DMA_SIZE_W-1:0]   desc_size [`NUM_REGIONS],
    input  logic [`NUM_REGIONS-1:0]  desc_req,
    input  logic                     burst_end,
    output logic [`HOST_ADDR_W-1:0]  dma_rd_addr,
    output logic [`DMA_SIZE_W-1:0]   dma_rd_size,
    output region_e                  region,
    output logic                     burst_start,
    output logic                     all_done
);

    seq_state_e state, next_state;
    region_e next_region;
    logic enter;

    function automatic region_e region_of(seq_state_e s);
        region_e r;
        case (s)
            SEQ_RT:    r = REGION_RT;
            SEQ_CONST: r = REGION_CONST;
            default:   r = REGION_CP;
        endcase
        return r;
    endfunction

    // A region without its request bit is passed in one cycle
    always_comb begin
        next_state = state;
        case (state)
            SEQ_IDLE: begin
                if (start_pulse) next_state = SEQ_CP;
            end
            SEQ_CP: begin
                if (!desc_req[REGION_CP] || burst_end) next_state = SEQ_RT;
            end
            SEQ_RT: begin
                if (!desc_req[REGION_RT] || burst_end) next_state = SEQ_CONST;
            end
            SEQ_CONST: begin
                if (!desc_req[REGION_CONST] || burst_end) next_state = SEQ_IDLE;
            end
            default: next_state = SEQ_IDLE;
        endcase
    end

    assign next_region = region_of(next_state);
    assign enter = (next_state != state) && (next_state != SEQ_IDLE)
                   && desc_req[next_region];

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state       <= SEQ_IDLE;
            region      <= REGION_CP;
            burst_start <= 1'b0;
            all_done    <= 1'b0;
        end else begin
            state       <= next_state;
            burst_start <= enter;
            all_done    <= (state != SEQ_IDLE) && (next_state == SEQ_IDLE);
            if (enter) region <= next_region;
        end
    end

    // Held until the burst ends
    always_ff @(posedge clk) begin
        if (enter) begin
            dma_rd_addr <= desc_addr[next_region];
            dma_rd_size <= desc_size[next_region];
        end
    end

    a_burst_in_region: assert property (@(posedge clk) disable iff (!rst_n)
        burst_start |-> state != SEQ_IDLE && desc_req[region]);

endmodule

// File: rtl/line_reader.sv
`timescale 1ns/1ns
`include "loader_settings.svh"

module line_reader import host_cfg_pkg::*, dma_rd_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     burst_start,
    input  logic [`DMA_SIZE_W-1:0]   dma_rd_size,
    input  region_e                  region,
    input  logic                     dma_rd_done,
    input  logic                     dma_empty,
    input  logic [`LINE_W-1:0]       dma_rd_data,
    output logic                     dma_rd_go,
    output logic                     dma_rd_en,
    output logic [`WORD_W-1:0]       word_data,
    output logic [`NUM_REGIONS-1:0]  word_we,
    output logic                     burst_end
);

    localparam int CNT_W = $clog2(`WORDS_PER_LINE);
    localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(`WORDS_PER_LINE - 1);

    line_state_e state, next_state;
    logic [`DMA_SIZE_W-1:0] lines_left;
    logic [CNT_W-1:0] word_cnt;
    logic done_seen;
    logic [`WORD_W-1:0] shreg [`WORDS_PER_LINE];

    assign dma_rd_en = (state == LR_WAIT) && (lines_left != '0) && !dma_empty;
    assign burst_end = (state == LR_FINISH) && done_seen;
    assign word_we   = (state == LR_UNPACK) ? (`NUM_REGIONS'(1) << region) : '0;
    assign word_data = shreg[0];

    always_comb begin
        next_state = state;
        case (state)
            LR_IDLE: begin
                if (burst_start) next_state = LR_WAIT;
            end
            LR_WAIT: begin
                if (lines_left == '0) next_state = LR_FINISH;
                else if (dma_rd_en) next_state = LR_UNPACK;
            end
            LR_UNPACK: begin
                if (word_cnt == LAST_WORD) next_state = LR_WAIT;
            end
            default: begin
                if (done_seen) next_state = LR_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state      <= LR_IDLE;
            lines_left <= '0;
            word_cnt   <= '0;
            dma_rd_go  <= 1'b0;
        end else begin
            state     <= next_state;
            dma_rd_go <= burst_start;
            if (burst_start) begin
                lines_left <= dma_rd_size;
            end else if (dma_rd_en) begin
                lines_left <= lines_left - 1'b1;
            end
            if (state == LR_UNPACK) word_cnt <= word_cnt + 1'b1;
            else word_cnt <= '0;
        end
    end

    // Done may arrive before the last line has been shifted out
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            done_seen <= 1'b0;
        end else if (burst_end) begin
            done_seen <= 1'b0;
        end else if (dma_rd_done) begin
            done_seen <= 1'b1;
        end
    end

    // Word 0 sits in the lowest bits of the line
    always_ff @(posedge clk) begin
        for (int i = 0; i < `WORDS_PER_LINE; i++) begin
            if (dma_rd_en) begin
                shreg[i] <= dma_rd_data[i*`WORD_W +: `WORD_W];
            end else if (state == LR_UNPACK && i < `WORDS_PER_LINE - 1) begin
                shreg[i] <= shreg[i+1];
            end
        end
    end

    a_pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
        dma_rd_en |-> !dma_empty ##1 word_we != '0);

    a_strobe_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(word_we));

endmodule

// File: rtl/host_loader.sv
`timescale 1ns/1ns
`include "loader_settings.svh"

module host_loader import host_cfg_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     mmio_wr_en,
    input  logic [`MMIO_ADDR_W-1:0]  mmio_wr_addr,
    input  logic [`HOST_ADDR_W-1:0]  mmio_wr_data,
    output status_e                  mmio_rd_data,
    output logic                     dma_rd_go,
    output logic [`HOST_ADDR_W-1:0]  dma_rd_addr,
    output logic [`DMA_SIZE_W-1:0]   dma_rd_size,
    output logic                     dma_rd_en,
    input  logic [`LINE_W-1:0]       dma_rd_data,
    input  logic                     dma_empty,
    input  logic                     dma_rd_done,
    output logic [`WORD_W-1:0]       word_data,
    output logic [`NUM_REGIONS-1:0]  word_we
);

    logic start_pulse;
    logic all_done;
    logic burst_start;
    logic burst_end;
    region_e region;
    logic [`HOST_ADDR_W-1:0] desc_addr [`NUM_REGIONS];
    logic [`DMA_SIZE_W-1:0] desc_size [`NUM_REGIONS];
    logic [`NUM_REGIONS-1:0] desc_req;

    region_cfg_regs u_cfg (
        .clk          (clk),
        .rst_n        (rst_n),
        .mmio_wr_en   (mmio_wr_en),
        .mmio_wr_addr (mmio_wr_addr),
        .mmio_wr_data (mmio_wr_data),
        .all_done     (all_done),
        .mmio_rd_data (mmio_rd_data),
        .start_pulse  (start_pulse),
        .desc_addr    (desc_addr),
        .desc_size    (desc_size),
        .desc_req     (desc_req)
    );

    region_sequencer u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_pulse (start_pulse),
        .desc_addr   (desc_addr),
        .desc_size   (desc_size),
        .desc_req    (desc_req),
        .burst_end   (burst_end),
        .dma_rd_addr (dma_rd_addr),
        .dma_rd_size (dma_rd_size),
        .region      (region),
        .burst_start (burst_start),
        .all_done    (all_done)
    );

    // One reader serves all regions since they never overlap
    line_reader u_reader (
        .clk         (clk),
        .rst_n       (rst_n),
        .burst_start (burst_start),
        .dma_rd_size (dma_rd_size),
        .region      (region),
        .dma_rd_done (dma_rd_done),
        .dma_empty   (dma_empty),
        .dma_rd_data (dma_rd_data),
        .dma_rd_go   (dma_rd_go),
        .dma_rd_en   (dma_rd_en),
        .word_data   (word_data),
        .word_we     (word_we),
        .burst_end   (burst_end)
    );

endmodule

// File: sim/dma_line_model.sv
`timescale 1ns/1ns
`include "loader_settings.svh"

module dma_line_model (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     dma_rd_go,
    input  logic [`HOST_ADDR_W-1:0]  dma_rd_addr,
    input  logic [`DMA_SIZE_W-1:0]   dma_rd_size,
    input  logic                     dma_rd_en,
    output logic [`LINE_W-1:0]       dma_rd_data,
    output logic                     dma_empty,
    output logic                     dma_rd_done
);

    integer seed;
    logic [`WORD_W-1:0] base;
    logic [`DMA_SIZE_W-1:0] lines_left;
    logic [`DMA_SIZE_W-1:0] left_next;
    int line_idx;
    int idx_next;

    initial seed = 32'ha5f0_36f1;

    // Word j of line n holds the low address bits plus 16n plus j
    function automatic logic [`LINE_W-1:0] make_line(logic [`WORD_W-1:0] b, int n);
        logic [`LINE_W-1:0] l;
        for (int j = 0; j < `WORDS_PER_LINE; j++) begin
            l[j*`WORD_W +: `WORD_W] = b + `WORD_W'(n * `WORDS_PER_LINE + j);
        end
        return l;
    endfunction

    assign left_next = dma_rd_en ? lines_left - 1'b1 : lines_left;
    assign idx_next  = dma_rd_en ? line_idx + 1 : line_idx;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            base        <= '0;
            lines_left  <= '0;
            line_idx    <= 0;
            dma_rd_data <= '0;
            dma_empty   <= 1'b1;
            dma_rd_done <= 1'b0;
        end else if (dma_rd_go) begin
            base        <= dma_rd_addr[`WORD_W-1:0];
            lines_left  <= dma_rd_size;
            line_idx    <= 0;
            dma_rd_data <= make_line(dma_rd_addr[`WORD_W-1:0], 0);
            dma_empty   <= 1'b1;
            dma_rd_done <= 1'b0;
        end else begin
            lines_left  <= left_next;
            line_idx    <= idx_next;
            dma_rd_data <= make_line(base, idx_next);
            dma_rd_done <= dma_rd_en && (left_next == '0);
            // Roughly one cycle in four looks empty
            dma_empty   <= (left_next == '0) || (($random(seed) & 3) == 0);
        end
    end

endmodule

// File: sim/tb_host_loader.sv
`timescale 1ns/1ns
`include "loader_settings.svh"

module tb_host_loader import host_cfg_pkg::*; ();

    // Three loads of 6, 3 and 7 lines
    localparam int TOTAL_LINES = 16;
    localparam int TIMEOUT_CYCLES = TOTAL_LINES * 40 + 200;

    logic clk;
    logic rst_n;
    logic mmio_wr_en;
    logic [`MMIO_ADDR_W-1:0] mmio_wr_addr;
    logic [`HOST_ADDR_W-1:0] mmio_wr_data;
    status_e mmio_rd_data;
    logic dma_rd_go;
    logic dma_rd_en;
    logic dma_empty;
    logic dma_rd_done;
    logic [`HOST_ADDR_W-1:0] dma_rd_addr;
    logic [`DMA_SIZE_W-1:0] dma_rd_size;
    logic [`LINE_W-1:0] dma_rd_data;
    logic [`WORD_W-1:0] word_data;
    logic [`NUM_REGIONS-1:0] word_we;

    logic [`HOST_ADDR_W-1:0] cfg_addr [`NUM_REGIONS];
    int cfg_lines [`NUM_REGIONS];
    logic cfg_req [`NUM_REGIONS];
    region_e exp_region [$];
    logic [`WORD_W-1:0] exp_word [$];
    logic [`HOST_ADDR_W-1:0] exp_burst_addr [$];
    logic [`DMA_SIZE_W-1:0] exp_burst_size [$];
    logic [`NUM_REGIONS-1:0] exp_we;
    logic [`WORD_W-1:0] exp_w;
    logic [`HOST_ADDR_W-1:0] exp_a;
    logic [`DMA_SIZE_W-1:0] exp_s;
    int cycle_cnt;
    int err_count;
    logic idle_check;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    host_loader UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .mmio_wr_en   (mmio_wr_en),
        .mmio_wr_addr (mmio_wr_addr),
        .mmio_wr_data (mmio_wr_data),
        .mmio_rd_data (mmio_rd_data),
        .dma_rd_go    (dma_rd_go),
        .dma_rd_addr  (dma_rd_addr),
        .dma_rd_size  (dma_rd_size),
        .dma_rd_en    (dma_rd_en),
        .dma_rd_data  (dma_rd_data),
        .dma_empty    (dma_empty),
        .dma_rd_done  (dma_rd_done),
        .word_data    (word_data),
        .word_we      (word_we)
    );

    dma_line_model u_dma (
        .clk         (clk),
        .rst_n       (rst_n),
        .dma_rd_go   (dma_rd_go),
        .dma_rd_addr (dma_rd_addr),
        .dma_rd_size (dma_rd_size),
        .dma_rd_en   (dma_rd_en),
        .dma_rd_data (dma_rd_data),
        .dma_empty   (dma_empty),
        .dma_rd_done (dma_rd_done)
    );

    task automatic stop_on_error();
        err_count++;
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [`WORD_W-1:0] expected_word(region_e r, int line, int word);
        return cfg_addr[r][`WORD_W-1:0] + `WORD_W'(line * `WORDS_PER_LINE + word);
    endfunction

    function automatic logic [`MMIO_ADDR_W-1:0] desc_address(logic req, int lines);
        logic [`MMIO_ADDR_W-1:0] a;
        a = '0;
        a[`REQ_BIT] = req;
        a[`REGION_SIZE_W:1] = `REGION_SIZE_W'(lines);
        return a;
    endfunction

    task automatic mmio_write(input logic [`MMIO_ADDR_W-1:0] addr,
                              input logic [`HOST_ADDR_W-1:0] data);
        @(posedge clk);
        mmio_wr_en   <= 1'b1;
        mmio_wr_addr <= addr;
        mmio_wr_data <= data;
        @(posedge clk);
        mmio_wr_en <= 1'b0;
    endtask

    task automatic queue_expected();
        region_e r;
        for (int i = 0; i < `NUM_REGIONS; i++) begin
            r = region_e'(i);
            if (cfg_req[i]) begin
                exp_burst_addr.push_back(cfg_addr[i]);
                exp_burst_size.push_back(`DMA_SIZE_W'(cfg_lines[i]));
                for (int n = 0; n < cfg_lines[i]; n++) begin
                    for (int j = 0; j < `WORDS_PER_LINE; j++) begin
                        exp_region.push_back(r);
                        exp_word.push_back(expected_word(r, n, j));
                    end
                end
            end
        end
    endtask

    task automatic run_load();
        queue_expected();
        idle_check <= 1'b1;
        mmio_write(desc_address(cfg_req[REGION_CP], 1), cfg_addr[REGION_CP]);
        mmio_write(desc_address(cfg_req[REGION_RT], cfg_lines[REGION_RT]), cfg_addr[REGION_RT]);
        mmio_write(desc_address(cfg_req[REGION_CONST], cfg_lines[REGION_CONST]),
                   cfg_addr[REGION_CONST]);
        idle_check <= 1'b0;
        mmio_write('0, '0);
        while (mmio_rd_data != STATUS_LOADED) @(posedge clk);
        assert (exp_word.size() == 0) else begin
            $display("Status reported loaded with %0d words still missing", exp_word.size());
            stop_on_error();
        end
        // Clear write
        mmio_write(`MMIO_ADDR_W'(1), '0);
        @(posedge clk);
        assert (mmio_rd_data == STATUS_BUSY) else begin
            $display("MISMATCH time=%0t mmio_rd_data got %0d expected 0", $time, mmio_rd_data);
            stop_on_error();
        end
    endtask

    // Word comparator
    always @(posedge clk) begin
        if (rst_n && word_we != '0) begin
            assert (exp_word.size() > 0) else begin
                $display("Unexpected word strobe %b at %0t", word_we, $time);
                stop_on_error();
            end
            exp_we = `NUM_REGIONS'(1) << exp_region.pop_front();
            exp_w = exp_word.pop_front();
            assert (word_we == exp_we) else begin
                $display("MISMATCH time=%0t word_we got %b expected %b", $time, word_we, exp_we);
                stop_on_error();
            end
            assert (word_data == exp_w) else begin
                $display("MISMATCH time=%0t word_data got %h expected %h",
                         $time, word_data, exp_w);
                stop_on_error();
            end
        end
    end

    // Burst address and size as seen by the DMA side
    always @(posedge clk) begin
        if (rst_n && dma_rd_go) begin
            assert (exp_burst_addr.size() > 0) else begin
                $display("Unexpected DMA burst start at %0t", $time);
                stop_on_error();
            end
            exp_a = exp_burst_addr.pop_front();
            exp_s = exp_burst_size.pop_front();
            assert (dma_rd_addr == exp_a) else begin
                $display("MISMATCH time=%0t dma_rd_addr got %h expected %h",
                         $time, dma_rd_addr, exp_a);
                stop_on_error();
            end
            assert (dma_rd_size == exp_s) else begin
                $display("MISMATCH time=%0t dma_rd_size got %0d expected %0d",
                         $time, dma_rd_size, exp_s);
                stop_on_error();
            end
        end
    end

    // Nothing moves before the arming write
    always @(posedge clk) begin
        if (rst_n && idle_check) begin
            assert (word_we == '0 && !dma_rd_en) else begin
                $display("Word strobe or FIFO pop seen before arming at %0t", $time);
                stop_on_error();
            end
            assert (mmio_rd_data == STATUS_BUSY) else begin
                $display("MISMATCH time=%0t mmio_rd_data got %0d expected 0",
                         $time, mmio_rd_data);
                stop_on_error();
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        assert (cycle_cnt < TIMEOUT_CYCLES) else begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_on_error();
        end
    end

    initial begin
        rst_n = 1'b0;
        mmio_wr_en = 1'b0;
        mmio_wr_addr = '0;
        mmio_wr_data = '0;
        idle_check = 1'b1;
        err_count = 0;
        cycle_cnt = 0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (5) @(posedge clk);

        // All regions requested
        cfg_addr[REGION_CP] = 64'h0000_0001_0000_1000;
        cfg_addr[REGION_RT] = 64'h0000_0000_2000_0400;
        cfg_addr[REGION_CONST] = 64'h0000_00ab_ffff_fff0;
        cfg_lines[REGION_CP] = 1;
        cfg_lines[REGION_RT] = 3;
        cfg_lines[REGION_CONST] = 2;
        cfg_req[REGION_CP] = 1'b1;
        cfg_req[REGION_RT] = 1'b1;
        cfg_req[REGION_CONST] = 1'b1;
        run_load();

        // rt skipped
        cfg_req[REGION_RT] = 1'b0;
        run_load();

        // Second full load with new descriptors
        cfg_addr[REGION_CP] = 64'h0000_0000_0000_0040;
        cfg_addr[REGION_RT] = 64'h0000_0002_8000_0000;
        cfg_addr[REGION_CONST] = 64'h0000_0000_0001_2340;
        cfg_lines[REGION_RT] = 2;
        cfg_lines[REGION_CONST] = 4;
        cfg_req[REGION_RT] = 1'b1;
        run_load();

        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
rtl/host_cfg_pkg.sv
rtl/dma_rd_pkg.sv
rtl/region_cfg_regs.sv
rtl/region_sequencer.sv
rtl/line_reader.sv
rtl/host_loader.sv
sim/dma_line_model.sv
sim/tb_host_loader.sv

// File: Bender.yml
package:
  name: host_loader

sources:
  - include_dirs:
      - include
    files:
      - rtl/host_cfg_pkg.sv
      - rtl/dma_rd_pkg.sv
      - rtl/region_cfg_regs.sv
      - rtl/region_sequencer.sv
      - rtl/line_reader.sv
      - rtl/host_loader.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/dma_line_model.sv
      - sim/tb_host_loader.sv
